/* Makefile */
# Verilator build, run and lint for the tunnel receive path

TOP ?= nettlp_rx_tb
SEED ?= 41
LOG ?= sim.log
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
FAIL_MSG := SOME TESTS FAILED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* source/credit_fifo.sv */
`default_nettype none
`timescale 1ns/1ps

module credit_fifo import nettlp_rx_pkg::*; (
	input wire eth_clk,
	input wire eth_rst,

	// write side, flow controlled by credits
	input wire push,
	input wire [data_w-1:0] push_data,
	input wire [keep_w-1:0] push_keep,
	input wire push_last,

	// read side
	input wire pop,
	output logic head_valid,
	output logic [data_w-1:0] head_data,
	output logic [keep_w-1:0] head_keep,
	output logic head_last,

	output logic credit_return
);

	logic [entry_w-1:0] mem [fifo_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [credit_w-1:0] occupancy;
	logic [entry_w-1:0] head_entry;

	// no full flag; the writer never pushes without a credit
	always_ff @(posedge eth_clk) begin
		if (push)
			mem[wr_ptr] <= {push_last, push_keep, push_data};
	end

	always_ff @(posedge eth_clk) begin
		if (eth_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occupancy <= '0;
			credit_return <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			occupancy <= occupancy + credit_w'(push) - credit_w'(pop);

			// one credit back per entry freed
			credit_return <= pop;
		end
	end

	// head is read straight from the array
	assign head_entry = mem[rd_ptr];
	assign head_valid = occupancy != '0;
	assign head_last = head_entry[entry_w-1];
	assign head_keep = head_entry[data_w +: keep_w];
	assign head_data = head_entry[data_w-1:0];

endmodule

`default_nettype wire

/* source/nettlp_rx_pkg.sv */
package nettlp_rx_pkg;

	// stream geometry
	localparam int data_w = 64;
	localparam int keep_w = 8;

	// receive buffer, one credit per entry
	localparam int fifo_depth = 16;
	localparam int ptr_w = 4;
	localparam int credit_w = 5;

	// buffer entry holds last, keep and data
	localparam int entry_w = data_w + keep_w + 1;

	// ethernet, ipv4, udp and tunnel header words ahead of the payload
	localparam int hdr_words = 6;

	// header field values the filter expects
	localparam logic [15:0] eth_p_ip = 16'h0800;
	localparam logic [7:0] ip_version_ihl = 8'h45;
	localparam logic [7:0] ip_proto_udp = 8'd17;

	// tunnel endpoints, network byte order
	localparam logic [31:0] local_ip = {8'd192, 8'd168, 8'd10, 8'd1};
	localparam logic [31:0] peer_ip = {8'd192, 8'd168, 8'd10, 8'd3};

	// both udp ports sit in the 0x3xxx range
	localparam logic [3:0] udp_port_nibble = 4'h3;

	// statistics counters
	localparam int cnt_w = 16;

endpackage

/* source/nettlp_rx_top.sv */
`default_nettype none
`timescale 1ns/1ps

module nettlp_rx_top import nettlp_rx_pkg::*; (
	input wire eth_clk,
	input wire eth_rst,

	// tunnel frames from the mac
	input wire in_valid,
	input wire in_last,
	input wire [keep_w-1:0] in_keep,
	input wire [data_w-1:0] in_data,

	// decapsulated payload stream
	output logic out_valid,
	output logic [data_w-1:0] out_data,
	output logic [keep_w-1:0] out_keep,
	output logic out_last,
	output logic out_error,
	input wire out_ready,

	output logic [cnt_w-1:0] pkt_count,
	output logic [cnt_w-1:0] trunc_count,
	output logic [cnt_w-1:0] drop_count
);

	// decapsulator to buffer
	logic push;
	logic [data_w-1:0] push_data;
	logic [keep_w-1:0] push_keep;
	logic push_last;
	logic credit_return;

	// buffer to egress
	logic pop;
	logic head_valid;
	logic [data_w-1:0] head_data;
	logic [keep_w-1:0] head_keep;
	logic head_last;

	udp_tunnel_decap u_decap (
		.eth_clk(eth_clk),
		.eth_rst(eth_rst),
		.in_valid(in_valid),
		.in_last(in_last),
		.in_keep(in_keep),
		.in_data(in_data),
		.push(push),
		.push_data(push_data),
		.push_keep(push_keep),
		.push_last(push_last),
		.credit_return(credit_return),
		.drop_count(drop_count)
	);

	credit_fifo u_fifo (
		.eth_clk(eth_clk),
		.eth_rst(eth_rst),
		.push(push),
		.push_data(push_data),
		.push_keep(push_keep),
		.push_last(push_last),
		.pop(pop),
		.head_valid(head_valid),
		.head_data(head_data),
		.head_keep(head_keep),
		.head_last(head_last),
		.credit_return(credit_return)
	);

	tlp_stream_out u_egress (
		.eth_clk(eth_clk),
		.eth_rst(eth_rst),
		.head_valid(head_valid),
		.head_data(head_data),
		.head_keep(head_keep),
		.head_last(head_last),
		.pop(pop),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_keep(out_keep),
		.out_last(out_last),
		.out_error(out_error),
		.out_ready(out_ready),
		.pkt_count(pkt_count),
		.trunc_count(trunc_count)
	);

endmodule

`default_nettype wire

/* source/tlp_stream_out.sv */
`default_nettype none
`timescale 1ns/1ps

module tlp_stream_out import nettlp_rx_pkg::*; (
	input wire eth_clk,
	input wire eth_rst,

	// buffer head
	input wire head_valid,
	input wire [data_w-1:0] head_data,
	input wire [keep_w-1:0] head_keep,
	input wire head_last,
	output logic pop,

	// output stream
	output logic out_valid,
	output logic [data_w-1:0] out_data,
	output logic [keep_w-1:0] out_keep,
	output logic out_last,
	output logic out_error,
	input wire out_ready,

	output logic [cnt_w-1:0] pkt_count,
	output logic [cnt_w-1:0] trunc_count
);

	logic out_accept;
	logic head_is_term;

	// output register is free when empty or leaving this cycle
	assign pop = head_valid && (!out_valid || out_ready);
	assign out_accept = out_valid && out_ready;

	// last with no bytes enabled is the truncation marker
	assign head_is_term = head_last && head_keep == '0;

	always_ff @(posedge eth_clk) begin
		if (eth_rst) begin
			out_valid <= 1'b0;
		end else begin
			if (pop)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
		end
	end

	always_ff @(posedge eth_clk) begin
		if (pop) begin
			out_data <= head_data;
			out_keep <= head_keep;
			out_last <= head_last;
			out_error <= head_is_term;
		end
	end

	// packets are counted as their last beat leaves
	always_ff @(posedge eth_clk) begin
		if (eth_rst) begin
			pkt_count <= '0;
			trunc_count <= '0;
		end else if (out_accept && out_last) begin
			if (out_error)
				trunc_count <= trunc_count + 1'b1;
			else
				pkt_count <= pkt_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* source/udp_tunnel_decap.sv */
`default_nettype none
`timescale 1ns/1ps

module udp_tunnel_decap import nettlp_rx_pkg::*; (
	input wire eth_clk,
	input wire eth_rst,

	// ethernet receive stream, no back-pressure
	input wire in_valid,
	input wire in_last,
	input wire [keep_w-1:0] in_keep,
	input wire [data_w-1:0] in_data,

	// buffer write side
	output logic push,
	output logic [data_w-1:0] push_data,
	output logic [keep_w-1:0] push_keep,
	output logic push_last,
	input wire credit_return,

	output logic [cnt_w-1:0] drop_count
);

	typedef enum logic [1:0] {
		st_hdr,
		st_payload,
		st_overflow,
		st_drain
	} state_t;

	state_t state;
	logic [2:0] hdr_cnt;
	logic [credit_w-1:0] credits;
	logic term_pending;

	// header words 1 to 4, checked one word later
	logic [data_w-1:0] hdr1_q;
	logic [data_w-1:0] hdr2_q;
	logic [data_w-1:0] hdr3_q;
	logic [data_w-1:0] hdr4_q;

	logic chk1;
	logic chk2;
	logic chk3;
	logic chk4;
	logic hdr_ok;

	logic credit_ok;
	logic word_push;
	logic term_push;
	logic word_lost;
	logic hdr_fail;

	// reverse the bytes of each 32-bit half in place
	function automatic logic [data_w-1:0] half_swap(input logic [data_w-1:0] w);
		logic [data_w-1:0] r;
		for (int i = 0; i < keep_w; i++) begin
			r[8*i +: 8] = w[8*((i & ~3) + 3 - (i & 3)) +: 8];
		end
		return r;
	endfunction

	// word 1: ethertype in bytes 12..13, version/ihl in byte 14
	assign chk1 = {hdr1_q[39:32], hdr1_q[47:40]} == eth_p_ip &&
		hdr1_q[55:48] == ip_version_ihl;

	// word 2: protocol in byte 23
	assign chk2 = hdr2_q[63:56] == ip_proto_udp;

	// word 3: source address in bytes 26..29
	assign chk3 = {hdr3_q[23:16], hdr3_q[31:24], hdr3_q[39:32], hdr3_q[47:40]} == peer_ip;

	// destination address straddles words 3 and 4, then the port high nibbles
	assign chk4 = {hdr3_q[55:48], hdr3_q[63:56], hdr4_q[7:0], hdr4_q[15:8]} == local_ip &&
		hdr4_q[23:20] == udp_port_nibble &&
		hdr4_q[39:36] == udp_port_nibble;

	always_comb begin
		case (hdr_cnt)
			3'd2: hdr_ok = chk1;
			3'd3: hdr_ok = chk2;
			3'd4: hdr_ok = chk3;
			3'd5: hdr_ok = chk4;
			default: hdr_ok = 1'b1;
		endcase
	end

	assign credit_ok = credits != '0;

	// a pending terminator goes ahead of any new payload
	assign word_push = state == st_payload && in_valid && credit_ok && !term_pending;
	assign word_lost = state == st_payload && in_valid && !(credit_ok && !term_pending);
	assign term_push = term_pending && credit_ok;
	assign hdr_fail = state == st_hdr && in_valid && !hdr_ok;

	always_ff @(posedge eth_clk) begin
		if (eth_rst) begin
			state <= st_hdr;
			hdr_cnt <= '0;
			credits <= credit_w'(fifo_depth);
			term_pending <= 1'b0;
			push <= 1'b0;
			drop_count <= '0;
		end else begin
			push <= word_push || term_push;
			credits <= credits + credit_w'(credit_return) - credit_w'(word_push || term_push);
			term_pending <= word_lost || (term_pending && !term_push);

			if (hdr_fail)
				drop_count <= drop_count + 1'b1;

			case (state)
				st_hdr: begin
					if (in_valid) begin
						if (!hdr_ok) begin
							hdr_cnt <= '0;
							if (!in_last)
								state <= st_drain;
						end else if (in_last) begin
							// runt frame, start over
							hdr_cnt <= '0;
						end else if (hdr_cnt == 3'(hdr_words - 1)) begin
							hdr_cnt <= '0;
							state <= st_payload;
						end else begin
							hdr_cnt <= hdr_cnt + 1'b1;
						end
					end
				end
				st_payload: begin
					if (in_valid) begin
						if (in_last)
							state <= st_hdr;
						else if (word_lost)
							state <= st_overflow;
					end
				end
				// rest of the frame is thrown away in both
				st_overflow, st_drain: begin
					if (in_valid && in_last)
						state <= st_hdr;
				end
				default: state <= st_hdr;
			endcase
		end
	end

	always_ff @(posedge eth_clk) begin
		if (state == st_hdr && in_valid) begin
			case (hdr_cnt)
				3'd1: hdr1_q <= in_data;
				3'd2: hdr2_q <= in_data;
				3'd3: hdr3_q <= in_data;
				3'd4: hdr4_q <= in_data;
				default: begin
				end
			endcase
		end

		if (word_push) begin
			push_data <= half_swap(in_data);
			push_keep <= in_keep;
			push_last <= in_last;
		end else if (term_push) begin
			// terminator marks a truncated frame
			push_data <= '0;
			push_keep <= '0;
			push_last <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verif/nettlp_rx_properties.sv */
`timescale 1ns/1ps

module nettlp_rx_properties import nettlp_rx_pkg::*; (
	input wire eth_clk,
	input wire eth_rst,
	input wire push,
	input wire pop,
	input wire head_valid,
	input wire credit_return,
	input wire [credit_w-1:0] occupancy
);

	// writer holds one credit per free entry
	a_no_overfill: assert property (@(posedge eth_clk) disable iff (eth_rst)
		push |-> occupancy != credit_w'(fifo_depth))
		else $error("push into a full buffer, occupancy %0d", occupancy);

	a_pop_has_head: assert property (@(posedge eth_clk) disable iff (eth_rst)
		pop |-> head_valid)
		else $error("pop from an empty buffer");

	// credit goes back exactly one cycle after the pop
	a_credit_follows_pop: assert property (@(posedge eth_clk) disable iff (eth_rst)
		credit_return == $past(pop))
		else $error("credit_return out of step with pop");

endmodule

/* verif/nettlp_rx_tb.sv */
`timescale 1ns/1ps

module nettlp_rx_tb import nettlp_rx_pkg::*; ();

	localparam int err_bit = data_w + keep_w + 1;
	localparam int last_bit = data_w + keep_w;
	localparam int no_limit = 1000;
	// 40 frames of up to 40 words plus gaps, four times over for back-pressure
	localparam int max_cycles = 40 * 125 * 4;

	logic eth_clk;
	logic eth_rst;
	logic in_valid;
	logic in_last;
	logic [keep_w-1:0] in_keep;
	logic [data_w-1:0] in_data;
	logic out_ready = 1'b0;
	logic out_valid;
	logic [data_w-1:0] out_data;
	logic [keep_w-1:0] out_keep;
	logic out_last;
	logic out_error;
	logic [cnt_w-1:0] pkt_count;
	logic [cnt_w-1:0] trunc_count;
	logic [cnt_w-1:0] drop_count;

	// 0 held low, 1 held high, 2 random
	int ready_mode = 0;
	int cycle_count = 0;
	int err_count = 0;
	int test_errs = 0;
	int pass_count = 0;
	int fail_count = 0;
	int exp_pkts = 0;
	int exp_truncs = 0;
	int exp_drops = 0;

	logic [7:0] hdr_bytes[hdr_words*keep_w];
	logic [data_w-1:0] frame_data[$];
	logic [keep_w-1:0] frame_keep[$];
	// {error, last, keep, data}
	logic [err_bit:0] exp_q[$];

	nettlp_rx_top DUT (.*);

	bind credit_fifo nettlp_rx_properties u_props (
		.eth_clk(eth_clk),
		.eth_rst(eth_rst),
		.push(push),
		.pop(pop),
		.head_valid(head_valid),
		.credit_return(credit_return),
		.occupancy(occupancy)
	);

	initial begin
		eth_clk = 1'b0;
		forever #4 eth_clk = ~eth_clk;
	end

	always @(posedge eth_clk) begin
		#1;
		if (ready_mode == 2)
			out_ready = ($urandom % 4) != 0;
		else
			out_ready = ready_mode == 1;
	end

	function automatic logic [7:0] byte_at(input logic [data_w-1:0] q[$], input int n);
		return q[n / keep_w][8 * (n % keep_w) +: 8];
	endfunction

	function automatic logic [15:0] rand_port();
		return {udp_port_nibble, 12'($urandom)};
	endfunction

	// expected beats of one frame, kept is how many payload words fit in the DUT
	function automatic int expect_beats(input logic [data_w-1:0] q[$],
		input logic [keep_w-1:0] kq[$], input int kept);
		logic [data_w-1:0] w;
		logic [data_w-1:0] sw;
		logic hdr_good;
		int n;
		hdr_good = {byte_at(q, 12), byte_at(q, 13)} == eth_p_ip &&
			byte_at(q, 14) == ip_version_ihl && byte_at(q, 23) == ip_proto_udp &&
			{byte_at(q, 26), byte_at(q, 27), byte_at(q, 28), byte_at(q, 29)} == peer_ip &&
			{byte_at(q, 30), byte_at(q, 31), byte_at(q, 32), byte_at(q, 33)} == local_ip &&
			(byte_at(q, 34) >> 4) == udp_port_nibble &&
			(byte_at(q, 36) >> 4) == udp_port_nibble;
		if (!hdr_good)
			return 0;
		n = 0;
		for (int i = hdr_words; i < q.size() && n < kept; i++) begin
			w = q[i];
			sw = {w[39:32], w[47:40], w[55:48], w[63:56], w[7:0], w[15:8], w[23:16], w[31:24]};
			exp_q.push_back({1'b0, i == q.size() - 1, kq[i], sw});
			n++;
		end
		// truncated frame ends in one error beat
		if (n < q.size() - hdr_words) begin
			exp_q.push_back({1'b1, 1'b1, {keep_w{1'b0}}, {data_w{1'b0}}});
			n++;
		end
		return n;
	endfunction

	task automatic put_field(input int offset, input logic [31:0] value, input int nbytes);
		for (int k = 0; k < nbytes; k++)
			hdr_bytes[offset + k] = value[8 * (nbytes - 1 - k) +: 8];
	endtask

	task automatic build_frame(
		input logic [15:0] etype,
		input logic [7:0] ver_ihl,
		input logic [7:0] proto,
		input logic [31:0] src_ip,
		input logic [31:0] dst_ip,
		input logic [15:0] sport,
		input logic [15:0] dport,
		input int plen
	);
		logic [data_w-1:0] w;
		int nb;
		frame_data = {};
		frame_keep = {};
		for (int i = 0; i < hdr_words * keep_w; i++)
			hdr_bytes[i] = 8'($urandom);
		put_field(12, 32'(etype), 2);
		put_field(14, 32'(ver_ihl), 1);
		put_field(23, 32'(proto), 1);
		put_field(26, src_ip, 4);
		put_field(30, dst_ip, 4);
		put_field(34, 32'(sport), 2);
		put_field(36, 32'(dport), 2);
		for (int i = 0; i < hdr_words; i++) begin
			for (int k = 0; k < keep_w; k++)
				w[8*k +: 8] = hdr_bytes[keep_w*i + k];
			frame_data.push_back(w);
			frame_keep.push_back({keep_w{1'b1}});
		end
		for (int i = 0; i < plen; i++) begin
			frame_data.push_back({$urandom, $urandom});
			frame_keep.push_back({keep_w{1'b1}});
		end
		// final word carries 1 to 8 bytes
		nb = 1 + $urandom % keep_w;
		frame_keep[frame_keep.size() - 1] = 8'((1 << nb) - 1);
	endtask

	task automatic build_good(input int plen);
		build_frame(eth_p_ip, ip_version_ihl, ip_proto_udp, peer_ip, local_ip,
			rand_port(), rand_port(), plen);
	endtask

	task automatic drive_frame(input bit gaps);
		for (int i = 0; i < frame_data.size(); i++) begin
			while (gaps && $urandom % 4 == 0) begin
				in_valid = 1'b0;
				@(posedge eth_clk);
				#1;
			end
			in_valid = 1'b1;
			in_data = frame_data[i];
			in_keep = frame_keep[i];
			in_last = i == frame_data.size() - 1;
			@(posedge eth_clk);
			#1;
		end
		in_valid = 1'b0;
		in_last = 1'b0;
	endtask

	task automatic send_frame(input int kept, input bit gaps);
		int beats;
		beats = expect_beats(frame_data, frame_keep, kept);
		if (beats == 0)
			exp_drops++;
		else if (kept < frame_data.size() - hdr_words)
			exp_truncs++;
		else
			exp_pkts++;
		drive_frame(gaps);
	endtask

	task automatic check_count(input string name, input logic [cnt_w-1:0] got, input int want);
		if (got != cnt_w'(want)) begin
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, name, got, want);
			err_count++;
		end
	endtask

	task automatic end_test(input string name);
		while (exp_q.size() != 0)
			@(posedge eth_clk);
		// room for stray beats and late counter updates
		repeat (20) @(posedge eth_clk);
		#1;
		check_count("pkt_count", pkt_count, exp_pkts);
		check_count("trunc_count", trunc_count, exp_truncs);
		check_count("drop_count", drop_count, exp_drops);
		if (err_count == test_errs) begin
			pass_count++;
			$display("test %s: pass", name);
		end else begin
			fail_count++;
			$display("test %s: fail", name);
		end
		test_errs = err_count;
	endtask

	always @(posedge eth_clk) begin
		logic [err_bit:0] e;
		if (!eth_rst && out_valid && out_ready) begin
			if (exp_q.size() == 0) begin
				$display("output beat at %0t arrived with nothing left to expect", $time);
				err_count++;
			end else begin
				e = exp_q.pop_front();
				if (out_error != e[err_bit] || out_last != e[last_bit] ||
					out_keep != e[data_w +: keep_w] ||
					(!e[err_bit] && out_data != e[data_w-1:0])) begin
					$display("mismatch at %0t: got err %0b last %0b keep %h data %h", $time,
						out_error, out_last, out_keep, out_data);
					$display("mismatch at %0t: want err %0b last %0b keep %h data %h", $time,
						e[err_bit], e[last_bit], e[data_w +: keep_w], e[data_w-1:0]);
					err_count++;
				end
			end
		end
	end

	always @(posedge eth_clk) begin
		cycle_count++;
		if (cycle_count >= max_cycles) begin
			$display("timeout: the run hung and stopped after %0d cycles", cycle_count);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	initial begin
		logic [15:0] etype;
		logic [7:0] ver;
		logic [7:0] proto;
		logic [31:0] sip;
		logic [31:0] dip;
		logic [15:0] sport;
		void'($urandom(41));
		eth_rst = 1'b1;
		in_valid = 1'b0;
		in_last = 1'b0;
		in_keep = '0;
		in_data = '0;
		repeat (8) @(posedge eth_clk);
		#1;
		eth_rst = 1'b0;

		@(posedge eth_clk);
		#1;
		if (out_valid !== 1'b0) begin
			$display("mismatch at %0t: out_valid high after reset", $time);
			err_count++;
		end
		end_test("reset state");

		ready_mode = 1;
		for (int i = 0; i < 10; i++) begin
			build_good(1 + $urandom % 34);
			send_frame(no_limit, 1'b1);
		end
		end_test("good frames");

		// each bad frame breaks one header rule, good frames in between
		for (int r = 0; r < 6; r++) begin
			build_good(1 + $urandom % 10);
			send_frame(no_limit, 1'b1);
			etype = eth_p_ip;
			ver = ip_version_ihl;
			proto = ip_proto_udp;
			sip = peer_ip;
			dip = local_ip;
			sport = rand_port();
			case (r)
				0: etype = 16'h86dd;
				1: ver = 8'h46;
				2: proto = 8'd6;
				3: sip = peer_ip + 32'd1;
				4: dip = local_ip + 32'd1;
				default: sport = 16'h5123;
			endcase
			build_frame(etype, ver, proto, sip, dip, sport, rand_port(), 1 + $urandom % 10);
			send_frame(no_limit, 1'b1);
		end
		build_good(1 + $urandom % 10);
		send_frame(no_limit, 1'b1);
		end_test("header filter");

		ready_mode = 2;
		for (int i = 0; i < 10; i++) begin
			build_good(1 + $urandom % 6);
			send_frame(no_limit, 1'b1);
		end
		end_test("random ready");

		// stalled output holds the buffer plus the egress register
		ready_mode = 0;
		repeat (2) @(posedge eth_clk);
		#1;
		build_good(24);
		send_frame(fifo_depth + 1, 1'b0);
		repeat (8) @(posedge eth_clk);
		#1;
		ready_mode = 1;
		build_good(1 + $urandom % 20);
		send_frame(no_limit, 1'b1);
		end_test("overflow");

		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0 && err_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* verilog.f */
source/nettlp_rx_pkg.sv
source/udp_tunnel_decap.sv
source/credit_fifo.sv
source/tlp_stream_out.sv
source/nettlp_rx_top.sv
verif/nettlp_rx_properties.sv
verif/nettlp_rx_tb.sv
